/* source/muscle_fixed_pkg.sv */
// signed fixed-point format shared by every datapath stage
package muscle_fixed_pkg;

    // word width and binary point position, Q16.16
    localparam int WIDTH     = 32;
    localparam int FRAC_BITS = 16;

    typedef logic signed [WIDTH-1:0] fixed_t;

    //////////////////////////////////////////////////////////////////////
    // constants for the length weight and the force derivative
    //////////////////////////////////////////////////////////////////////
    localparam fixed_t FX_HALF  = 32'sh0000_8000;
    localparam fixed_t FX_ONE   = 32'sh0001_0000;
    localparam fixed_t FX_TWO   = 32'sh0002_0000;
    localparam fixed_t FX_THREE = 32'sh0003_0000;
    localparam fixed_t FX_FOUR  = 32'sh0004_0000;
    localparam fixed_t FX_EIGHT = 32'sh0008_0000;

    // full-width product, then drop the extra fraction bits
    // arithmetic shift means rounding toward minus infinity
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [2*WIDTH-1:0] prod;
        prod = a * b;
        return fixed_t'(prod >>> FRAC_BITS);
    endfunction

    // integer spike count to fixed point, upper bits fall off
    function automatic fixed_t fx_from_count(input logic [WIDTH-1:0] cnt);
        logic [WIDTH-1:0] shifted;
        shifted = cnt << FRAC_BITS;
        return fixed_t'(shifted);
    endfunction

endpackage

/* source/muscle_ctrl_pkg.sv */
// step sequencing definitions for the muscle update controller
package muscle_ctrl_pkg;

    // one state per datapath stage, each held for a single cycle
    //   ST_IDLE   waiting for a step strobe
    //   ST_TWITCH twitch filter updates h
    //   ST_WEIGHT length weight updates A
    //   ST_FORCE  integrator updates T
    //   ST_DONE   result valid, done pulse
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TWITCH,
        ST_WEIGHT,
        ST_FORCE,
        ST_DONE
    } step_state_t;

endpackage

/* source/muscle_step_ctrl.sv */
// sequences one muscle update step over the three datapath stages
module muscle_step_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic step_i,
    output logic sample_en_o,
    output logic twitch_en_o,
    output logic weight_en_o,
    output logic force_en_o,
    output logic busy_o,
    output logic done_o
);

    muscle_ctrl_pkg::step_state_t state;
    muscle_ctrl_pkg::step_state_t state_next;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            // a strobe outside idle never reaches here, so it is dropped
            muscle_ctrl_pkg::ST_IDLE: begin
                if (step_i) begin
                    state_next = muscle_ctrl_pkg::ST_TWITCH;
                end
            end
            muscle_ctrl_pkg::ST_TWITCH: state_next = muscle_ctrl_pkg::ST_WEIGHT;
            muscle_ctrl_pkg::ST_WEIGHT: state_next = muscle_ctrl_pkg::ST_FORCE;
            muscle_ctrl_pkg::ST_FORCE:  state_next = muscle_ctrl_pkg::ST_DONE;
            muscle_ctrl_pkg::ST_DONE:   state_next = muscle_ctrl_pkg::ST_IDLE;
            default:                    state_next = muscle_ctrl_pkg::ST_IDLE;
        endcase
    end

    // state register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= muscle_ctrl_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobe and status decode
    //////////////////////////////////////////////////////////////////////
    // inputs are captured on the accepting edge itself
    assign sample_en_o = step_i && (state == muscle_ctrl_pkg::ST_IDLE);

    // one stage enable per state
    assign twitch_en_o = (state == muscle_ctrl_pkg::ST_TWITCH);
    assign weight_en_o = (state == muscle_ctrl_pkg::ST_WEIGHT);
    assign force_en_o  = (state == muscle_ctrl_pkg::ST_FORCE);

    // status
    assign done_o = (state == muscle_ctrl_pkg::ST_DONE);
    assign busy_o = (state != muscle_ctrl_pkg::ST_IDLE);

endmodule

/* source/twitch_filter.sv */
// second-order twitch response, h[n] = b1*x[n-1] - a1*h[n-1] - a2*h[n-2]
// poles sit at z = a, both coefficients derived from a = 0.9
module twitch_filter #(
    parameter muscle_fixed_pkg::fixed_t COEF_B1 = 32'sd4096,
    parameter muscle_fixed_pkg::fixed_t COEF_A1 = -32'sd117965,
    parameter muscle_fixed_pkg::fixed_t COEF_A2 = 32'sd53084
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  sample_en_i,
    input  logic                                  twitch_en_i,
    input  logic [muscle_fixed_pkg::WIDTH-1:0]    spike_cnt_i,
    output muscle_fixed_pkg::fixed_t              twitch_o
);

    // newest sample, waiting for the next twitch update
    muscle_fixed_pkg::fixed_t x_new;
    // sample used by the current update, one step old
    muscle_fixed_pkg::fixed_t x_prev;
    // output history
    muscle_fixed_pkg::fixed_t h1;
    muscle_fixed_pkg::fixed_t h2;
    muscle_fixed_pkg::fixed_t h_new;

    //////////////////////////////////////////////////////////////////////
    // difference equation
    //////////////////////////////////////////////////////////////////////
    // feedback terms subtract, so a negative a1 gives positive gain on h1
    assign h_new = muscle_fixed_pkg::fx_mul(COEF_B1, x_prev)
                 - muscle_fixed_pkg::fx_mul(COEF_A1, h1)
                 - muscle_fixed_pkg::fx_mul(COEF_A2, h2);

    // input capture on the accepting edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_new <= '0;
        end else if (sample_en_i) begin
            x_new <= muscle_fixed_pkg::fx_from_count(spike_cnt_i);
        end
    end

    // history shift, the input lags the output by one step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_prev <= '0;
            h1     <= '0;
            h2     <= '0;
        end else if (twitch_en_i) begin
            h2     <= h1;
            h1     <= h_new;
            x_prev <= x_new;
        end
    end

    assign twitch_o = h1;

endmodule

/* source/length_weight.sv */
// scales the twitch activation by a piecewise-quadratic weight of length
module length_weight (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sample_en_i,
    input  logic                     weight_en_i,
    input  muscle_fixed_pkg::fixed_t pos_i,
    input  muscle_fixed_pkg::fixed_t twitch_i,
    output muscle_fixed_pkg::fixed_t active_o
);

    // length held for the whole step
    muscle_fixed_pkg::fixed_t pos_q;
    muscle_fixed_pkg::fixed_t pos_sq;
    // rising branch -4x^2 + 8x - 3, peaks at 1 for x = 1
    muscle_fixed_pkg::fixed_t w_rise;
    // falling branch -x^2 + 2x, also 1 at x = 1, 0 at x = 2
    muscle_fixed_pkg::fixed_t w_fall;
    muscle_fixed_pkg::fixed_t weight;
    muscle_fixed_pkg::fixed_t active_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_q <= '0;
        end else if (sample_en_i) begin
            pos_q <= pos_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // weight curve
    //////////////////////////////////////////////////////////////////////
    // only the square rounds, the integer multiples are exact
    assign pos_sq = muscle_fixed_pkg::fx_mul(pos_q, pos_q);
    assign w_rise = muscle_fixed_pkg::fx_mul(muscle_fixed_pkg::FX_EIGHT, pos_q)
                  - muscle_fixed_pkg::fx_mul(muscle_fixed_pkg::FX_FOUR, pos_sq)
                  - muscle_fixed_pkg::FX_THREE;
    assign w_fall = muscle_fixed_pkg::fx_mul(muscle_fixed_pkg::FX_TWO, pos_q) - pos_sq;

    // region select, signed compare so short or negative lengths give 0
    always_comb begin
        if (pos_q <= muscle_fixed_pkg::FX_HALF) begin
            weight = '0;
        end else if (pos_q <= muscle_fixed_pkg::FX_ONE) begin
            weight = w_rise;
        end else if (pos_q <= muscle_fixed_pkg::FX_TWO) begin
            weight = w_fall;
        end else begin
            weight = '0;
        end
    end

    // weighted activation A
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q <= '0;
        end else if (weight_en_i) begin
            active_q <= muscle_fixed_pkg::fx_mul(weight, twitch_i);
        end
    end

    assign active_o = active_q;

endmodule

/* source/force_integrator.sv */
// total muscle force, forward Euler on
//   dT = k_len*(x - 1) + k_vel*v - k_decay*T + k_act*A
// time step is 2^-DT_SHIFT
module force_integrator #(
    parameter muscle_fixed_pkg::fixed_t K_LEN    = 32'sd13369344,
    parameter muscle_fixed_pkg::fixed_t K_VEL    = 32'sd8912896,
    parameter muscle_fixed_pkg::fixed_t K_DECAY  = 32'sd276562,
    parameter muscle_fixed_pkg::fixed_t K_ACT    = 32'sd178258,
    parameter int                       DT_SHIFT = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sample_en_i,
    input  logic                     force_en_i,
    input  muscle_fixed_pkg::fixed_t pos_i,
    input  muscle_fixed_pkg::fixed_t vel_i,
    input  muscle_fixed_pkg::fixed_t active_i,
    output muscle_fixed_pkg::fixed_t force_o
);

    muscle_fixed_pkg::fixed_t pos_q;
    muscle_fixed_pkg::fixed_t vel_q;
    muscle_fixed_pkg::fixed_t force_q;
    // stretch relative to rest length 1.0
    muscle_fixed_pkg::fixed_t stretch;
    muscle_fixed_pkg::fixed_t d_force;
    muscle_fixed_pkg::fixed_t d_force_scaled;

    // length and velocity held for the whole step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_q <= '0;
            vel_q <= '0;
        end else if (sample_en_i) begin
            pos_q <= pos_i;
            vel_q <= vel_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // force derivative
    //////////////////////////////////////////////////////////////////////
    assign stretch = pos_q - muscle_fixed_pkg::FX_ONE;

    // passive spring + damping - decay + active drive
    assign d_force = muscle_fixed_pkg::fx_mul(K_LEN, stretch)
                   + muscle_fixed_pkg::fx_mul(K_VEL, vel_q)
                   - muscle_fixed_pkg::fx_mul(K_DECAY, force_q)
                   + muscle_fixed_pkg::fx_mul(K_ACT, active_i);

    // multiply by dt, arithmetic so negative slopes keep their sign
    assign d_force_scaled = d_force >>> DT_SHIFT;

    // integrator
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            force_q <= '0;
        end else if (force_en_i) begin
            force_q <= force_q + d_force_scaled;
        end
    end

    assign force_o = force_q;

endmodule

/* source/muscle_core.sv */
// one muscle, spike count in, twitch, activation and force out
// a step takes the controller through twitch, weight and force in order
module muscle_core #(
    // twitch filter coefficients, a = 0.9
    parameter muscle_fixed_pkg::fixed_t COEF_B1  = 32'sd4096,
    parameter muscle_fixed_pkg::fixed_t COEF_A1  = -32'sd117965,
    parameter muscle_fixed_pkg::fixed_t COEF_A2  = 32'sd53084,
    // force constants, 204.0 136.0 4.22 2.72
    parameter muscle_fixed_pkg::fixed_t K_LEN    = 32'sd13369344,
    parameter muscle_fixed_pkg::fixed_t K_VEL    = 32'sd8912896,
    parameter muscle_fixed_pkg::fixed_t K_DECAY  = 32'sd276562,
    parameter muscle_fixed_pkg::fixed_t K_ACT    = 32'sd178258,
    parameter int                       DT_SHIFT = 10
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               step_i,
    input  logic [muscle_fixed_pkg::WIDTH-1:0] spike_cnt_i,
    input  muscle_fixed_pkg::fixed_t           pos_i,
    input  muscle_fixed_pkg::fixed_t           vel_i,
    output logic                               busy_o,
    output logic                               done_o,
    output muscle_fixed_pkg::fixed_t           twitch_o,
    output muscle_fixed_pkg::fixed_t           active_o,
    output muscle_fixed_pkg::fixed_t           force_o
);

    // stage strobes
    logic sample_en;
    logic twitch_en;
    logic weight_en;
    logic force_en;

    muscle_step_ctrl u_ctrl (
        .clk(clk), .reset(reset), .step_i(step_i),
        .sample_en_o(sample_en), .twitch_en_o(twitch_en),
        .weight_en_o(weight_en), .force_en_o(force_en),
        .busy_o(busy_o), .done_o(done_o)
    );

    // h ready one edge after twitch_en
    twitch_filter #(.COEF_B1(COEF_B1), .COEF_A1(COEF_A1), .COEF_A2(COEF_A2)) u_twitch (
        .clk(clk), .reset(reset), .sample_en_i(sample_en), .twitch_en_i(twitch_en),
        .spike_cnt_i(spike_cnt_i), .twitch_o(twitch_o)
    );

    // A from the h just produced
    length_weight u_weight (
        .clk(clk), .reset(reset), .sample_en_i(sample_en), .weight_en_i(weight_en),
        .pos_i(pos_i), .twitch_i(twitch_o), .active_o(active_o)
    );

    force_integrator #(
        .K_LEN(K_LEN), .K_VEL(K_VEL), .K_DECAY(K_DECAY), .K_ACT(K_ACT), .DT_SHIFT(DT_SHIFT)
    ) u_force (
        .clk(clk), .reset(reset), .sample_en_i(sample_en), .force_en_i(force_en),
        .pos_i(pos_i), .vel_i(vel_i), .active_i(active_o), .force_o(force_o)
    );

endmodule

/* tests/muscle_core_chk.sv */
// protocol checks on the step controller strobes
module muscle_core_chk (
    input logic clk,
    input logic reset,
    input logic sample_en_i,
    input logic twitch_en_i,
    input logic weight_en_i,
    input logic force_en_i,
    input logic busy_i,
    input logic done_i
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done_i |=> !done_i)
        else $error("done held for more than one cycle");

    // a new step is only taken from idle, and the controller goes busy right after
    sample_when_idle: assert property (@(posedge clk) disable iff (reset)
        sample_en_i |-> !busy_i ##1 busy_i)
        else $error("sample strobe while busy or busy not raised");

    // at most one stage strobe per cycle
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sample_en_i, twitch_en_i, weight_en_i, force_en_i}))
        else $error("stage strobes overlap");

    // stages run back to back after the sample edge
    stage_order: assert property (@(posedge clk) disable iff (reset)
        sample_en_i |=> twitch_en_i ##1 weight_en_i ##1 force_en_i)
        else $error("stage strobes out of order");

endmodule

/* tests/muscle_core_tb.sv */
module muscle_core_tb;

    // default coefficients of the design, kept here for the model
    localparam muscle_fixed_pkg::fixed_t M_B1    = 32'sd4096;
    localparam muscle_fixed_pkg::fixed_t M_A1    = -32'sd117965;
    localparam muscle_fixed_pkg::fixed_t M_A2    = 32'sd53084;
    localparam muscle_fixed_pkg::fixed_t M_KLEN  = 32'sd13369344;
    localparam muscle_fixed_pkg::fixed_t M_KVEL  = 32'sd8912896;
    localparam muscle_fixed_pkg::fixed_t M_KDEC  = 32'sd276562;
    localparam muscle_fixed_pkg::fixed_t M_KACT  = 32'sd178258;
    localparam int                       M_SHIFT = 10;
    // about 60 steps of 5 cycles, with a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic                     clk;
    logic                     reset;
    logic                     step_i;
    logic [31:0]              spike_cnt_i;
    muscle_fixed_pkg::fixed_t pos_i;
    muscle_fixed_pkg::fixed_t vel_i;
    logic                     busy_o;
    logic                     done_o;
    muscle_fixed_pkg::fixed_t twitch_o;
    muscle_fixed_pkg::fixed_t active_o;
    muscle_fixed_pkg::fixed_t force_o;

    int errors;
    int checks;
    int cycles;
    int seed_val;

    // model state: input history, twitch history, activation, force
    muscle_fixed_pkg::fixed_t m_x_new, m_x_prev, m_h1, m_h2, m_a, m_t;

    muscle_core uut (
        .clk(clk), .reset(reset), .step_i(step_i), .spike_cnt_i(spike_cnt_i),
        .pos_i(pos_i), .vel_i(vel_i), .busy_o(busy_o), .done_o(done_o),
        .twitch_o(twitch_o), .active_o(active_o), .force_o(force_o)
    );

    bind muscle_step_ctrl muscle_core_chk u_chk (
        .clk(clk), .reset(reset), .sample_en_i(sample_en_o), .twitch_en_i(twitch_en_o),
        .weight_en_i(weight_en_o), .force_en_i(force_en_o), .busy_i(busy_o), .done_i(done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic signed [63:0] actual,
                               input logic signed [63:0] expected, input string msg);
        checks++;
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, msg, actual, expected);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, one full step
    //////////////////////////////////////////////////////////////////////
    task automatic model_step(input int spike, input muscle_fixed_pkg::fixed_t pos,
                              input muscle_fixed_pkg::fixed_t vel);
        muscle_fixed_pkg::fixed_t h, sq, w, dt;
        m_x_new = muscle_fixed_pkg::fx_from_count(spike);
        // input is used one step late
        h = muscle_fixed_pkg::fx_mul(M_B1, m_x_prev) - muscle_fixed_pkg::fx_mul(M_A1, m_h1)
          - muscle_fixed_pkg::fx_mul(M_A2, m_h2);
        m_h2 = m_h1;
        m_h1 = h;
        m_x_prev = m_x_new;
        // weight regions, integer multiples are exact shifts
        sq = muscle_fixed_pkg::fx_mul(pos, pos);
        if (pos <= muscle_fixed_pkg::FX_HALF || pos > muscle_fixed_pkg::FX_TWO)
            w = 0;
        else if (pos <= muscle_fixed_pkg::FX_ONE)
            w = (pos <<< 3) - (sq <<< 2) - muscle_fixed_pkg::FX_THREE;
        else
            w = (pos <<< 1) - sq;
        m_a = muscle_fixed_pkg::fx_mul(w, m_h1);
        // euler step on the force
        dt = muscle_fixed_pkg::fx_mul(M_KLEN, pos - muscle_fixed_pkg::FX_ONE)
           + muscle_fixed_pkg::fx_mul(M_KVEL, vel) - muscle_fixed_pkg::fx_mul(M_KDEC, m_t)
           + muscle_fixed_pkg::fx_mul(M_KACT, m_a);
        m_t = m_t + (dt >>> M_SHIFT);
    endtask

    // drive one step, check latency, pulse width and all three results
    task automatic run_step(input int spike, input muscle_fixed_pkg::fixed_t pos,
                            input muscle_fixed_pkg::fixed_t vel);
        int edges;
        check_value(busy_o, 0, "busy before step");
        spike_cnt_i = spike;
        pos_i = pos;
        vel_i = vel;
        step_i = 1'b1;
        @(posedge clk);
        #1 step_i = 1'b0;
        model_step(spike, pos, vel);
        edges = 0;
        while (!done_o && edges < 10) begin
            check_value(busy_o, 1, "busy during step");
            @(posedge clk);
            #1 edges++;
        end
        check_value(edges, 3, "done latency");
        check_value(twitch_o, m_h1, "twitch");
        check_value(active_o, m_a, "active");
        check_value(force_o, m_t, "force");
        @(posedge clk);
        #1 check_value(done_o, 0, "done width");
        check_value(busy_o, 0, "busy after done");
    endtask

    task automatic check_reset_values;
        check_value(busy_o, 0, "reset busy");
        check_value(done_o, 0, "reset done");
        check_value(twitch_o, 0, "reset twitch");
        check_value(active_o, 0, "reset active");
        check_value(force_o, 0, "reset force");
    endtask

    task automatic check_step_timing;
        run_step(0, muscle_fixed_pkg::FX_ONE, 0);
    endtask

    // unit impulse, first output still zero from the input delay
    task automatic twitch_impulse;
        run_step(1, muscle_fixed_pkg::FX_ONE, 0);
        check_value(twitch_o, 0, "twitch input delay");
        for (int i = 0; i < 7; i++) begin
            run_step(0, muscle_fixed_pkg::FX_ONE, 0);
        end
    endtask

    // one length per weight region
    task automatic length_regions;
        run_step(0, 32'sh0000_4000, 0);
        check_value(active_o, 0, "weight below 0.5");
        run_step(0, 32'sh0000_C000, 0);
        run_step(0, 32'sh0001_8000, 0);
        run_step(0, 32'sh0002_8000, 0);
        check_value(active_o, 0, "weight above 2");
    endtask

    task automatic force_random_walk;
        int spike, pos, vel;
        for (int i = 0; i < 40; i++) begin
            spike = $urandom % 8;
            pos = 32768 + int'($urandom % 98305);
            vel = int'($urandom % 8193) - 4096;
            run_step(spike, pos, vel);
        end
    endtask

    // strobes while busy and during done must be dropped
    task automatic busy_strobe_ignored;
        int pulses;
        pulses = 0;
        spike_cnt_i = 3;
        pos_i = muscle_fixed_pkg::FX_ONE;
        vel_i = 0;
        step_i = 1'b1;
        model_step(3, muscle_fixed_pkg::FX_ONE, 0);
        for (int i = 1; i <= 12; i++) begin
            @(posedge clk);
            #1 if (done_o) pulses++;
            step_i = (i == 1 || i == 3 || i == 4);
            spike_cnt_i = (i == 1) ? 5 : 3;
        end
        check_value(pulses, 1, "done pulses with busy strobes");
        check_value(busy_o, 0, "busy after ignored strobes");
        check_value(twitch_o, m_h1, "twitch after ignored strobes");
        check_value(active_o, m_a, "active after ignored strobes");
        check_value(force_o, m_t, "force after ignored strobes");
        run_step(0, muscle_fixed_pkg::FX_ONE, 0);
    endtask

    task automatic finish_run;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        errors = 0;
        checks = 0;
        seed_val = $urandom(88);
        reset = 1'b1;
        step_i = 1'b0;
        spike_cnt_i = '0;
        pos_i = '0;
        vel_i = '0;
        {m_x_new, m_x_prev, m_h1, m_h2, m_a, m_t} = '0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        check_reset_values();
        check_step_timing();
        twitch_impulse();
        length_regions();
        force_random_walk();
        busy_strobe_ignored();
        finish_run();
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run timed out after %0d cycles", cycles);
        errors++;
        finish_run();
    end

endmodule

/* src.f */
source/muscle_fixed_pkg.sv
source/muscle_ctrl_pkg.sv
source/muscle_step_ctrl.sv
source/twitch_filter.sv
source/length_weight.sv
source/force_integrator.sv
source/muscle_core.sv
tests/muscle_core_chk.sv
tests/muscle_core_tb.sv
